//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = mpss_tb
RTL_TOP   = mpss
FILELIST  = mpss.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) logic/*.sv logic/*.svh verif/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- logic/gpio.sv
`timescale 1ns/1ps
`default_nettype none

module gpio (
	input  wire                        clk_i,
	input  wire                        arst_n_i,
	input  wire                        req_i,
	input  wire                        we_i,
	input  wire mpss_bus_pkg::addr_t   addr_i,
	input  wire mpss_bus_pkg::be_t     be_i,
	input  wire mpss_bus_pkg::data_t   wdata_i,
	input  wire mpss_bus_pkg::data_t   gpio_i,
	output logic                       ack_o,
	output logic                       resp_o,
	output mpss_bus_pkg::data_t        rdata_o,
	output mpss_bus_pkg::data_t        gpio_o
);

	mpss_bus_pkg::data_t out_reg;
	mpss_bus_pkg::data_t sync_q;
	mpss_bus_pkg::data_t in_reg;
	logic [mpss_map_pkg::SLAVE_SEL_BIT-1:0] ofs;

	assign ofs    = addr_i[mpss_map_pkg::SLAVE_SEL_BIT-1:0];
	assign ack_o  = req_i;
	assign gpio_o = out_reg;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_reg <= '0;
			sync_q  <= '0;
			in_reg  <= '0;
			resp_o  <= 1'b0;
		end else begin
			sync_q <= gpio_i; // first sync stage.
			in_reg <= sync_q;
			resp_o <= req_i && !we_i;
			if (req_i && we_i && ofs == mpss_map_pkg::GPIO_OUT_OFS) begin
				for (int b = 0; b < $bits(mpss_bus_pkg::be_t); b++) begin
					if (be_i[b])
						out_reg[8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_i && !we_i) begin
			case (ofs)
				mpss_map_pkg::GPIO_OUT_OFS: rdata_o <= out_reg;
				mpss_map_pkg::GPIO_IN_OFS:  rdata_o <= in_reg;
				default:                    rdata_o <= '0; // unmapped.
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/mpss.sv
`timescale 1ns/1ps
`default_nettype none

module mpss (
	input  wire                        clk_i,
	input  wire                        arst_n_i,

	input  wire                        m0_req_i,
	input  wire                        m0_we_i,
	input  wire mpss_bus_pkg::addr_t   m0_addr_i,
	input  wire mpss_bus_pkg::be_t     m0_be_i,
	input  wire mpss_bus_pkg::data_t   m0_wdata_i,
	output logic                       m0_ack_o,
	output logic                       m0_resp_o,
	output mpss_bus_pkg::data_t        m0_rdata_o,

	input  wire                        m1_req_i,
	input  wire                        m1_we_i,
	input  wire mpss_bus_pkg::addr_t   m1_addr_i,
	input  wire mpss_bus_pkg::be_t     m1_be_i,
	input  wire mpss_bus_pkg::data_t   m1_wdata_i,
	output logic                       m1_ack_o,
	output logic                       m1_resp_o,
	output mpss_bus_pkg::data_t        m1_rdata_o,

	input  wire mpss_bus_pkg::data_t   gpio_bi_i,
	output mpss_bus_pkg::data_t        gpio_bo_o
);

	logic srst_n;

	// ram side.
	logic                s0_req;
	logic                s0_we;
	mpss_bus_pkg::addr_t s0_addr;
	mpss_bus_pkg::be_t   s0_be;
	mpss_bus_pkg::data_t s0_wdata;
	logic                s0_ack;
	logic                s0_resp;
	mpss_bus_pkg::data_t s0_rdata;

	// gpio side.
	logic                s1_req;
	logic                s1_we;
	mpss_bus_pkg::addr_t s1_addr;
	mpss_bus_pkg::be_t   s1_be;
	mpss_bus_pkg::data_t s1_wdata;
	logic                s1_ack;
	logic                s1_resp;
	mpss_bus_pkg::data_t s1_rdata;

	reset_cntrl reset_cntrl (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.srst_n_o (srst_n)
	);

	xbar_buffered xbar (
		.clk_i      (clk_i),
		.arst_n_i   (srst_n),
		.m0_req_i   (m0_req_i),
		.m0_we_i    (m0_we_i),
		.m0_addr_i  (m0_addr_i),
		.m0_be_i    (m0_be_i),
		.m0_wdata_i (m0_wdata_i),
		.m0_ack_o   (m0_ack_o),
		.m0_resp_o  (m0_resp_o),
		.m0_rdata_o (m0_rdata_o),
		.m1_req_i   (m1_req_i),
		.m1_we_i    (m1_we_i),
		.m1_addr_i  (m1_addr_i),
		.m1_be_i    (m1_be_i),
		.m1_wdata_i (m1_wdata_i),
		.m1_ack_o   (m1_ack_o),
		.m1_resp_o  (m1_resp_o),
		.m1_rdata_o (m1_rdata_o),
		.s0_req_o   (s0_req),
		.s0_we_o    (s0_we),
		.s0_addr_o  (s0_addr),
		.s0_be_o    (s0_be),
		.s0_wdata_o (s0_wdata),
		.s0_ack_i   (s0_ack),
		.s0_resp_i  (s0_resp),
		.s0_rdata_i (s0_rdata),
		.s1_req_o   (s1_req),
		.s1_we_o    (s1_we),
		.s1_addr_o  (s1_addr),
		.s1_be_o    (s1_be),
		.s1_wdata_o (s1_wdata),
		.s1_ack_i   (s1_ack),
		.s1_resp_i  (s1_resp),
		.s1_rdata_i (s1_rdata)
	);

	ram_slave ram (
		.clk_i    (clk_i),
		.arst_n_i (srst_n),
		.req_i    (s0_req),
		.we_i     (s0_we),
		.addr_i   (s0_addr),
		.be_i     (s0_be),
		.wdata_i  (s0_wdata),
		.ack_o    (s0_ack),
		.resp_o   (s0_resp),
		.rdata_o  (s0_rdata)
	);

	gpio gpio (
		.clk_i    (clk_i),
		.arst_n_i (srst_n),
		.req_i    (s1_req),
		.we_i     (s1_we),
		.addr_i   (s1_addr),
		.be_i     (s1_be),
		.wdata_i  (s1_wdata),
		.gpio_i   (gpio_bi_i),
		.ack_o    (s1_ack),
		.resp_o   (s1_resp),
		.rdata_o  (s1_rdata),
		.gpio_o   (gpio_bo_o)
	);

endmodule

`default_nettype wire

//--- logic/mpss_bus_pkg.sv
`default_nettype none

package mpss_bus_pkg;

	// widths of the shared req/ack bus.
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int BE_W   = DATA_W / 8;

	// byte address.
	typedef logic [ADDR_W-1:0] addr_t;

	// read and write data word.
	typedef logic [DATA_W-1:0] data_t;

	// one enable per byte lane.
	typedef logic [BE_W-1:0] be_t;

endpackage

`default_nettype wire

//--- logic/mpss_map_pkg.sv
`default_nettype none

package mpss_map_pkg;

	// target slave, 0 is the data ram and 1 is gpio.
	typedef logic [0:0] slave_id_t;

	// issuing master on the crossbar.
	typedef logic [0:0] master_id_t;

	// address bit that splits ram and gpio windows.
	localparam int SLAVE_SEL_BIT = 12;

	// register offsets inside the gpio window.
	localparam logic [SLAVE_SEL_BIT-1:0] GPIO_OUT_OFS = 12'h000;
	localparam logic [SLAVE_SEL_BIT-1:0] GPIO_IN_OFS  = 12'h004;

	// per-slave round robin state, master granted last.
	typedef enum logic [0:0] {
		LAST_M0 = 1'b0,
		LAST_M1 = 1'b1
	} arb_state_t;

endpackage

`default_nettype wire

//--- logic/mpss_settings.svh
`ifndef MPSS_SETTINGS_SVH
`define MPSS_SETTINGS_SVH

// data ram size in 32-bit words, addresses wrap around it.
`define MPSS_RAM_WORDS 1024
// request queue depth per master.
`define MPSS_XBAR_DEPTH 4
// clocks of internal reset after external release.
`define MPSS_RST_CYCLES 4

`endif

//--- logic/ram_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpss_settings.svh"

module ram_slave (
	input  wire                        clk_i,
	input  wire                        arst_n_i,
	input  wire                        req_i,
	input  wire                        we_i,
	input  wire mpss_bus_pkg::addr_t   addr_i,
	input  wire mpss_bus_pkg::be_t     be_i,
	input  wire mpss_bus_pkg::data_t   wdata_i,
	output logic                       ack_o,
	output logic                       resp_o,
	output mpss_bus_pkg::data_t        rdata_o
);

	localparam int AW = $clog2(`MPSS_RAM_WORDS);

	mpss_bus_pkg::data_t mem [`MPSS_RAM_WORDS];
	logic [AW-1:0]       word_addr;

	assign word_addr = addr_i[AW+1:2]; // upper bits alias.
	assign ack_o     = req_i;

	always_ff @(posedge clk_i) begin
		if (req_i && we_i) begin
			for (int b = 0; b < $bits(mpss_bus_pkg::be_t); b++) begin
				if (be_i[b])
					mem[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
		if (req_i && !we_i)
			rdata_o <= mem[word_addr];
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			resp_o <= 1'b0;
		else
			resp_o <= req_i && !we_i; // one cycle after accept.
	end

endmodule

`default_nettype wire

//--- logic/reset_cntrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpss_settings.svh"

module reset_cntrl (
	input  wire  clk_i,
	input  wire  arst_n_i,
	output logic srst_n_o
);

	localparam int CW = $clog2(`MPSS_RST_CYCLES + 1);

	logic [CW-1:0] cnt;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt      <= CW'(`MPSS_RST_CYCLES);
			srst_n_o <= 1'b0;
		end else begin
			if (cnt != '0)
				cnt <= cnt - 1'b1; // stretch.
			srst_n_o <= (cnt <= CW'(1)); // release on the last count.
		end
	end

endmodule

`default_nettype wire

//--- logic/xbar_buffered.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpss_settings.svh"

module xbar_buffered #(
	parameter int DEPTH = `MPSS_XBAR_DEPTH
) (
	input  wire                        clk_i,
	input  wire                        arst_n_i,

	input  wire                        m0_req_i,
	input  wire                        m0_we_i,
	input  wire mpss_bus_pkg::addr_t   m0_addr_i,
	input  wire mpss_bus_pkg::be_t     m0_be_i,
	input  wire mpss_bus_pkg::data_t   m0_wdata_i,
	output logic                       m0_ack_o,
	output logic                       m0_resp_o,
	output mpss_bus_pkg::data_t        m0_rdata_o,

	input  wire                        m1_req_i,
	input  wire                        m1_we_i,
	input  wire mpss_bus_pkg::addr_t   m1_addr_i,
	input  wire mpss_bus_pkg::be_t     m1_be_i,
	input  wire mpss_bus_pkg::data_t   m1_wdata_i,
	output logic                       m1_ack_o,
	output logic                       m1_resp_o,
	output mpss_bus_pkg::data_t        m1_rdata_o,

	output logic                       s0_req_o,
	output logic                       s0_we_o,
	output mpss_bus_pkg::addr_t        s0_addr_o,
	output mpss_bus_pkg::be_t          s0_be_o,
	output mpss_bus_pkg::data_t        s0_wdata_o,
	input  wire                        s0_ack_i,
	input  wire                        s0_resp_i,
	input  wire mpss_bus_pkg::data_t   s0_rdata_i,

	output logic                       s1_req_o,
	output logic                       s1_we_o,
	output mpss_bus_pkg::addr_t        s1_addr_o,
	output mpss_bus_pkg::be_t          s1_be_o,
	output mpss_bus_pkg::data_t        s1_wdata_o,
	input  wire                        s1_ack_i,
	input  wire                        s1_resp_i,
	input  wire mpss_bus_pkg::data_t   s1_rdata_i
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
	endfunction

	// master side, indexed by master.
	logic                m_req   [2];
	logic                m_we    [2];
	mpss_bus_pkg::addr_t m_addr  [2];
	mpss_bus_pkg::be_t   m_be    [2];
	mpss_bus_pkg::data_t m_wdata [2];
	logic                m_resp  [2];
	mpss_bus_pkg::data_t m_rdata [2];

	// request queues.
	logic                q_we    [2][DEPTH];
	mpss_bus_pkg::addr_t q_addr  [2][DEPTH];
	mpss_bus_pkg::be_t   q_be    [2][DEPTH];
	mpss_bus_pkg::data_t q_wdata [2][DEPTH];
	logic [PTR_W-1:0]    wr_ptr  [2];
	logic [PTR_W-1:0]    rd_ptr  [2];
	logic [CNT_W-1:0]    cnt     [2];
	logic                full    [2];
	logic                push    [2];
	logic                pop     [2];
	mpss_map_pkg::slave_id_t head_tgt [2];

	// slave side, indexed by slave.
	logic                s_req   [2];
	logic                s_we    [2];
	mpss_bus_pkg::addr_t s_addr  [2];
	mpss_bus_pkg::be_t   s_be    [2];
	mpss_bus_pkg::data_t s_wdata [2];
	logic                s_ack   [2];
	logic                s_resp  [2];
	mpss_bus_pkg::data_t s_rdata [2];
	logic                want    [2][2]; // [slave][master].
	mpss_map_pkg::master_id_t grant [2];
	mpss_map_pkg::arb_state_t last  [2];

	// read owners in issue order, per slave.
	mpss_map_pkg::master_id_t ord_q [2][DEPTH];
	logic [PTR_W-1:0]    ord_wr  [2];
	logic [PTR_W-1:0]    ord_rd  [2];

	assign m_req[0]   = m0_req_i;
	assign m_we[0]    = m0_we_i;
	assign m_addr[0]  = m0_addr_i;
	assign m_be[0]    = m0_be_i;
	assign m_wdata[0] = m0_wdata_i;
	assign m_req[1]   = m1_req_i;
	assign m_we[1]    = m1_we_i;
	assign m_addr[1]  = m1_addr_i;
	assign m_be[1]    = m1_be_i;
	assign m_wdata[1] = m1_wdata_i;

	assign m0_ack_o   = push[0];
	assign m0_resp_o  = m_resp[0];
	assign m0_rdata_o = m_rdata[0];
	assign m1_ack_o   = push[1];
	assign m1_resp_o  = m_resp[1];
	assign m1_rdata_o = m_rdata[1];

	assign s0_req_o   = s_req[0];
	assign s0_we_o    = s_we[0];
	assign s0_addr_o  = s_addr[0];
	assign s0_be_o    = s_be[0];
	assign s0_wdata_o = s_wdata[0];
	assign s1_req_o   = s_req[1];
	assign s1_we_o    = s_we[1];
	assign s1_addr_o  = s_addr[1];
	assign s1_be_o    = s_be[1];
	assign s1_wdata_o = s_wdata[1];

	assign s_ack[0]   = s0_ack_i;
	assign s_resp[0]  = s0_resp_i;
	assign s_rdata[0] = s0_rdata_i;
	assign s_ack[1]   = s1_ack_i;
	assign s_resp[1]  = s1_resp_i;
	assign s_rdata[1] = s1_rdata_i;

	always_comb begin
		for (int m = 0; m < 2; m++) begin
			full[m]     = (cnt[m] == CNT_W'(DEPTH));
			push[m]     = m_req[m] && !full[m]; // accepted the cycle it is seen.
			head_tgt[m] = q_addr[m][rd_ptr[m]][mpss_map_pkg::SLAVE_SEL_BIT];
		end
	end

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			for (int m = 0; m < 2; m++)
				want[s][m] = (cnt[m] != '0) && (head_tgt[m] == mpss_map_pkg::slave_id_t'(s));
			s_req[s] = want[s][0] || want[s][1];
			if (want[s][0] && want[s][1])
				grant[s] = (last[s] == mpss_map_pkg::LAST_M0) ? 1'b1 : 1'b0; // turn of the other.
			else
				grant[s] = want[s][1] ? 1'b1 : 1'b0;
			s_we[s]    = q_we[grant[s]][rd_ptr[grant[s]]];
			s_addr[s]  = q_addr[grant[s]][rd_ptr[grant[s]]];
			s_be[s]    = q_be[grant[s]][rd_ptr[grant[s]]];
			s_wdata[s] = q_wdata[grant[s]][rd_ptr[grant[s]]];
		end
	end

	always_comb begin
		for (int m = 0; m < 2; m++) begin
			pop[m] = 1'b0;
			for (int s = 0; s < 2; s++) begin
				if (s_req[s] && s_ack[s] && grant[s] == mpss_map_pkg::master_id_t'(m))
					pop[m] = 1'b1;
			end
		end
	end

	// resp goes to the oldest read owner of that slave.
	always_comb begin
		for (int m = 0; m < 2; m++) begin
			m_resp[m]  = 1'b0;
			m_rdata[m] = '0;
			for (int s = 0; s < 2; s++) begin
				if (s_resp[s] && ord_q[s][ord_rd[s]] == mpss_map_pkg::master_id_t'(m)) begin
					m_resp[m]  = 1'b1;
					m_rdata[m] = s_rdata[s];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		for (int m = 0; m < 2; m++) begin
			if (push[m]) begin
				q_we[m][wr_ptr[m]]    <= m_we[m];
				q_addr[m][wr_ptr[m]]  <= m_addr[m];
				q_be[m][wr_ptr[m]]    <= m_be[m];
				q_wdata[m][wr_ptr[m]] <= m_wdata[m];
			end
		end
		for (int s = 0; s < 2; s++) begin
			if (s_req[s] && s_ack[s] && !s_we[s])
				ord_q[s][ord_wr[s]] <= grant[s];
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int m = 0; m < 2; m++) begin
				wr_ptr[m] <= '0;
				rd_ptr[m] <= '0;
				cnt[m]    <= '0;
			end
			for (int s = 0; s < 2; s++) begin
				last[s]   <= mpss_map_pkg::LAST_M1; // m0 wins the first tie.
				ord_wr[s] <= '0;
				ord_rd[s] <= '0;
			end
		end else begin
			for (int m = 0; m < 2; m++) begin
				if (push[m])
					wr_ptr[m] <= ptr_next(wr_ptr[m]);
				if (pop[m])
					rd_ptr[m] <= ptr_next(rd_ptr[m]);
				if (push[m] && !pop[m])
					cnt[m] <= cnt[m] + 1'b1;
				else if (pop[m] && !push[m])
					cnt[m] <= cnt[m] - 1'b1;
			end
			for (int s = 0; s < 2; s++) begin
				if (s_req[s] && s_ack[s]) begin
					last[s] <= (grant[s] == 1'b1) ? mpss_map_pkg::LAST_M1 : mpss_map_pkg::LAST_M0;
					if (!s_we[s])
						ord_wr[s] <= ptr_next(ord_wr[s]);
				end
				if (s_resp[s])
					ord_rd[s] <= ptr_next(ord_rd[s]);
			end
		end
	end

endmodule

`default_nettype wire

//--- mpss.f
+incdir+logic
logic/mpss_bus_pkg.sv
logic/mpss_map_pkg.sv
logic/reset_cntrl.sv
logic/xbar_buffered.sv
logic/ram_slave.sv
logic/gpio.sv
logic/mpss.sv
verif/mpss_tb.sv

//--- verif/mpss_input.txt
# phase master we addr be wdata gpio_in exp_rdata
# addr, be, wdata, gpio_in and exp_rdata in hex; exp_rdata is checked on reads only
2 0 1 00000010 f 11223344 00000000 00000000
2 0 1 00000010 5 aabbccdd 00000000 00000000
2 0 1 00002010 8 77000000 00000000 00000000
2 0 0 00000010 f 00000000 00000000 77bb33dd
2 1 1 00000020 f cafef00d 00000000 00000000
2 1 1 00000020 2 00001200 00000000 00000000
2 1 0 00004020 f 00000000 00000000 cafe120d
3 0 1 00001000 f 12345678 5a5aa5a5 00000000
3 0 1 00001000 3 ffffabcd 5a5aa5a5 00000000
3 0 0 00001000 f 00000000 5a5aa5a5 1234abcd
3 0 0 00001004 f 00000000 5a5aa5a5 5a5aa5a5
4 0 1 00000100 f 01010101 00000000 00000000
4 0 0 00000100 f 00000000 00000000 01010101
4 0 0 00000010 f 00000000 00000000 77bb33dd
4 1 1 00000104 f 02020202 00000000 00000000
4 1 0 00000104 f 00000000 00000000 02020202
4 1 0 00000020 f 00000000 00000000 cafe120d
5 0 1 00000200 f 10000001 00000000 00000000
5 0 1 00000204 f 20000002 00000000 00000000
5 0 1 00000208 f 30000003 00000000 00000000
5 0 1 0000020c f 40000004 00000000 00000000
5 0 0 00000200 f 00000000 00000000 10000001
5 0 0 00000204 f 00000000 00000000 20000002
5 0 0 00000208 f 00000000 00000000 30000003
5 0 0 0000020c f 00000000 00000000 40000004
5 0 0 00000100 f 00000000 00000000 01010101
5 1 1 00000300 f 0badcafe 00000000 00000000
5 1 0 00000300 f 00000000 00000000 0badcafe
5 1 0 00000104 f 00000000 00000000 02020202
5 1 0 00000020 f 00000000 00000000 cafe120d

//--- verif/mpss_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mpss_tb;

	localparam string INPUT_FILE = "verif/mpss_input.txt";
	localparam int    MAX_LINES  = 64;
	localparam int    BURST_PHASE = 5; // back-to-back phase, no idle gaps.

	logic                clk = 1'b0;
	logic                arst_n;
	logic                req   [2];
	logic                we    [2];
	mpss_bus_pkg::addr_t addr  [2];
	mpss_bus_pkg::be_t   be    [2];
	mpss_bus_pkg::data_t wdata [2];
	mpss_bus_pkg::data_t gpio_bi;

	logic                m0_ack;
	logic                m0_resp;
	mpss_bus_pkg::data_t m0_rdata;
	logic                m1_ack;
	logic                m1_resp;
	mpss_bus_pkg::data_t m1_rdata;
	mpss_bus_pkg::data_t gpio_bo;

	// stimulus lines from the data file.
	int                  ln_phase  [MAX_LINES];
	int                  ln_master [MAX_LINES];
	logic                ln_we     [MAX_LINES];
	mpss_bus_pkg::addr_t ln_addr   [MAX_LINES];
	mpss_bus_pkg::be_t   ln_be     [MAX_LINES];
	mpss_bus_pkg::data_t ln_wdata  [MAX_LINES];
	mpss_bus_pkg::data_t ln_gpio   [MAX_LINES];
	mpss_bus_pkg::data_t ln_exp    [MAX_LINES];
	int                  n_lines;
	int                  max_phase;

	mpss_bus_pkg::data_t exp_q0 [$]; // reads in flight, master 0.
	mpss_bus_pkg::data_t exp_q1 [$];
	mpss_bus_pkg::data_t gpio_model = '0;
	logic                stalled [2];
	int                  seed = 6024;
	int                  cycles = 0;
	int                  limit = 0;

	mpss dut (
		.clk_i      (clk),
		.arst_n_i   (arst_n),
		.m0_req_i   (req[0]),
		.m0_we_i    (we[0]),
		.m0_addr_i  (addr[0]),
		.m0_be_i    (be[0]),
		.m0_wdata_i (wdata[0]),
		.m0_ack_o   (m0_ack),
		.m0_resp_o  (m0_resp),
		.m0_rdata_o (m0_rdata),
		.m1_req_i   (req[1]),
		.m1_we_i    (we[1]),
		.m1_addr_i  (addr[1]),
		.m1_be_i    (be[1]),
		.m1_wdata_i (wdata[1]),
		.m1_ack_o   (m1_ack),
		.m1_resp_o  (m1_resp),
		.m1_rdata_o (m1_rdata),
		.gpio_bi_i  (gpio_bi),
		.gpio_bo_o  (gpio_bo)
	);

	always #4 clk = ~clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_data(input mpss_bus_pkg::data_t got, input mpss_bus_pkg::data_t exp,
			input string what);
		if (got !== exp)
			stop_run($sformatf("Fail at %0t: %s, got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Fail at %0t: %s, got %b expected %b", $time, what, got, exp));
	endtask

	function automatic logic ack_of(input int m);
		return (m == 1) ? m1_ack : m0_ack;
	endfunction

	function automatic logic is_gpio_out(input mpss_bus_pkg::addr_t a);
		return a[mpss_map_pkg::SLAVE_SEL_BIT] &&
			(a[mpss_map_pkg::SLAVE_SEL_BIT-1:0] == mpss_map_pkg::GPIO_OUT_OFS);
	endfunction

	function automatic mpss_bus_pkg::data_t merge_bytes(input mpss_bus_pkg::data_t old,
			input mpss_bus_pkg::data_t wd, input mpss_bus_pkg::be_t lanes);
		mpss_bus_pkg::data_t r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (lanes[b])
				r[8*b +: 8] = wd[8*b +: 8];
		end
		return r;
	endfunction

	task automatic load_lines();
		int fd;
		int code;
		string line;
		int ph, mm, w;
		logic [31:0] a, wd, gi, ex;
		logic [3:0] b;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0)
			stop_run("could not open the stimulus file verif/mpss_input.txt");
		n_lines = 0;
		max_phase = 1;
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
				code = $sscanf(line, "%d %d %d %h %h %h %h %h", ph, mm, w, a, b, wd, gi, ex);
				if (code == 8 && n_lines < MAX_LINES) begin
					ln_phase[n_lines]  = ph;
					ln_master[n_lines] = mm;
					ln_we[n_lines]     = w[0];
					ln_addr[n_lines]   = a;
					ln_be[n_lines]     = b;
					ln_wdata[n_lines]  = wd;
					ln_gpio[n_lines]   = gi;
					ln_exp[n_lines]    = ex;
					if (ph > max_phase)
						max_phase = ph;
					n_lines++;
				end
			end
		end
		$fclose(fd);
		if (n_lines == 0)
			stop_run("the stimulus file holds no bus operations");
	endtask

	task automatic take_resp(input int m, input mpss_bus_pkg::data_t rd);
		mpss_bus_pkg::data_t exp_v;
		if (m == 0) begin
			if (exp_q0.size() == 0)
				stop_run("master 0 got a read response with no read outstanding");
			exp_v = exp_q0.pop_front();
			check_data(rd, exp_v, "m0 rdata");
		end else begin
			if (exp_q1.size() == 0)
				stop_run("master 1 got a read response with no read outstanding");
			exp_v = exp_q1.pop_front();
			check_data(rd, exp_v, "m1 rdata");
		end
	endtask

	// resp is one cycle wide, sample mid-cycle.
	always @(negedge clk) begin
		if (m0_resp === 1'b1)
			take_resp(0, m0_rdata);
		if (m1_resp === 1'b1)
			take_resp(1, m1_rdata);
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit != 0 && cycles > limit)
			stop_run($sformatf("timed out after %0d cycles with the bus still busy", cycles));
	end

	task automatic run_stream(input int m, input int ph);
		int gap;
		logic got_ack;
		for (int i = 0; i < n_lines; i++) begin
			if (ln_phase[i] == ph && ln_master[i] == m) begin
				gap = (ph == BURST_PHASE) ? 0 : ($random(seed) & 3);
				repeat (gap) @(posedge clk);
				if (gap != 0)
					#1;
				req[m]   = 1'b1;
				we[m]    = ln_we[i];
				addr[m]  = ln_addr[i];
				be[m]    = ln_be[i];
				wdata[m] = ln_wdata[i];
				got_ack  = 1'b0;
				while (!got_ack) begin
					@(negedge clk);
					if (ack_of(m))
						got_ack = 1'b1;
					else
						stalled[m] = 1'b1; // queue full.
				end
				@(posedge clk);
				if (!ln_we[i]) begin
					if (m == 0)
						exp_q0.push_back(ln_exp[i]);
					else
						exp_q1.push_back(ln_exp[i]);
				end
				#1;
				req[m] = 1'b0;
				if (ln_we[i] && is_gpio_out(ln_addr[i])) begin
					gpio_model = merge_bytes(gpio_model, ln_wdata[i], ln_be[i]);
					repeat (2) @(posedge clk);
					#1;
					check_data(gpio_bo, gpio_model, "gpio_bo_o after write");
				end
			end
		end
	endtask

	task automatic run_phase(input int ph);
		int first;
		first = -1;
		for (int i = n_lines - 1; i >= 0; i--) begin
			if (ln_phase[i] == ph)
				first = i;
		end
		if (first >= 0) begin
			gpio_bi = ln_gpio[first];
			stalled[0] = 1'b0;
			stalled[1] = 1'b0;
			repeat (4) @(posedge clk); // through the input synchronizer.
			#1;
			fork
				run_stream(0, ph);
				run_stream(1, ph);
			join
			while (exp_q0.size() != 0 || exp_q1.size() != 0)
				@(posedge clk);
			repeat (10) @(posedge clk); // drain queued writes.
			#1;
			if (ph == BURST_PHASE)
				check_flag(stalled[0], 1'b1, "m0 ack drop while both masters hit the ram");
		end
	endtask

	task automatic check_reset_state();
		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			check_flag(m0_resp, 1'b0, "m0 resp after reset");
			check_flag(m1_resp, 1'b0, "m1 resp after reset");
			check_flag(m0_ack, 1'b0, "m0 ack after reset");
			check_flag(m1_ack, 1'b0, "m1 ack after reset");
			check_data(gpio_bo, '0, "gpio_bo_o after reset");
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		arst_n  = 1'b0;
		gpio_bi = '0;
		for (int m = 0; m < 2; m++) begin
			req[m]     = 1'b0;
			we[m]      = 1'b0;
			addr[m]    = '0;
			be[m]      = '0;
			wdata[m]   = '0;
			stalled[m] = 1'b0;
		end
		load_lines();
		limit = n_lines * 20 + 200;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_reset_state();
		for (int ph = 2; ph <= max_phase; ph++)
			run_phase(ph);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire
